// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= sd_cmd_tb
RTL_TOP ?= sd_cmd_top
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall

FAIL_MSG = Test failures found
PASS_MSG = All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without passing"; exit 1; fi
	@echo "Simulation PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== cmd_master/cmd_master.sv ====
// ============================================================
// SD command master FSM
// ============================================================

`default_nettype none

`include "sd_cmd_settings.svh"

module cmd_master
	import sd_cmd_pkg::*, sd_host_reg_pkg::*;
(
	input wire logic CLK_host,
	input wire logic reset,
	input wire logic physical_inactive,
	input wire logic new_cmd,
	input wire cmd_req_t cmd_req,
	input wire logic ack_in,
	input wire logic req_in,
	input wire cmd_token_t cmd_response,
	input wire logic timeout_error_from_physical,
	output logic new_cmd_to_physical,
	output cmd_req_t cmd_to_physical,
	output logic ack_out,
	output host_status_t cmd_status,
	output host_status_en_t cmd_status_en
);

	typedef enum logic [3:0] {
		st_waiting_cmd = 4'b0001,
		st_setup = 4'b0010,
		st_waiting_response = 4'b0100,
		st_finishing = 4'b1000
	} master_state_t;

	master_state_t state;
	master_state_t state_next;
	logic timeout_q;
	cmd_req_t req_q;

	always_comb begin
		state_next = state;
		unique case (state)
			st_waiting_cmd: begin
				if (new_cmd)
					state_next = st_setup;
			end
			st_setup: begin
				if (ack_in)
					state_next = st_waiting_response;
			end
			st_waiting_response: begin
				if (req_in || timeout_error_from_physical)
					state_next = st_finishing;
			end
			st_finishing: begin
				state_next = st_waiting_cmd;
			end
			default: state_next = st_waiting_cmd;
		endcase
	end

	always_ff @(posedge CLK_host) begin
		if (reset || physical_inactive) begin
			state <= st_waiting_cmd;
			timeout_q <= 1'b0;
		end else begin
			state <= state_next;
			// A response wins over a timeout in the same cycle
			if (state == st_waiting_response && state_next == st_finishing)
				timeout_q <= timeout_error_from_physical && !req_in;
		end
	end

	// Command captured when accepted
	always_ff @(posedge CLK_host) begin
		if (state == st_waiting_cmd && new_cmd)
			req_q <= cmd_req;
	end

	assign new_cmd_to_physical = (state == st_setup);
	assign cmd_to_physical = req_q;
	assign ack_out = (state == st_waiting_response) && req_in;

	always_comb begin
		cmd_status = '0;
		cmd_status_en = '0;
		cmd_status.cmd_busy = (state == st_setup) || (state == st_waiting_response);
		if (state == st_finishing) begin
			cmd_status_en = '1;
			if (timeout_q) begin
				cmd_status.timeout_error = 1'b1;
			end else begin
				cmd_status.cmd_complete = 1'b1;
				cmd_status.response_status =
					cmd_response[`SD_RSP_STATUS_MSB:`SD_RSP_STATUS_LSB];
			end
		end
	end

endmodule

`default_nettype wire

// ==== cmd_physical/cmd_response_timer.sv ====
// ============================================================
// NCR response timer
// ============================================================

`default_nettype none

`include "sd_cmd_settings.svh"

module cmd_response_timer (
	input wire logic CLK_host,
	input wire logic reset,
	input wire logic physical_inactive,
	input wire logic tx_done,
	input wire logic rsp_start,
	output logic timeout_error_from_physical
);

	localparam logic [`SD_CMD_TIMER_BITS-1:0] ncr_max =
		`SD_CMD_TIMER_BITS'(`SD_CMD_NCR_MAX);

	logic armed;
	logic [`SD_CMD_TIMER_BITS-1:0] count_q;

	// A start bit on the last allowed cycle still counts
	assign timeout_error_from_physical = armed && (count_q == ncr_max) && !rsp_start;

	always_ff @(posedge CLK_host) begin
		if (reset || physical_inactive) begin
			armed <= 1'b0;
			count_q <= '0;
		end else if (tx_done) begin
			armed <= 1'b1;
			count_q <= '0;
		end else if (armed) begin
			if (rsp_start || count_q == ncr_max)
				armed <= 1'b0;
			else
				count_q <= count_q + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== cmd_physical/cmd_rx_capture.sv ====
// ============================================================
// CMD response capture
// ============================================================

`default_nettype none

`include "sd_cmd_settings.svh"

module cmd_rx_capture
	import sd_cmd_pkg::*;
(
	input wire logic CLK_host,
	input wire logic reset,
	input wire logic physical_inactive,
	input wire logic tx_done,
	input wire logic ack_out,
	input wire logic cmd_in,
	output logic rsp_start,
	output logic req_in,
	output cmd_token_t cmd_response
);

	localparam logic [5:0] last_bit = 6'(`SD_CMD_FRAME_BITS - 1);

	typedef enum logic [1:0] {
		rx_idle,
		rx_wait_start,
		rx_receive,
		rx_hold
	} rx_state_t;

	rx_state_t state;
	logic [5:0] bit_cnt;
	cmd_token_t shift_q;

	assign rsp_start = (state == rx_wait_start) && !cmd_in;
	assign req_in = (state == rx_hold);
	assign cmd_response = shift_q;

	always_ff @(posedge CLK_host) begin
		if (reset || physical_inactive) begin
			state <= rx_idle;
			bit_cnt <= '0;
		end else if (tx_done) begin
			state <= rx_wait_start;
			bit_cnt <= '0;
		end else begin
			unique case (state)
				rx_wait_start: begin
					// Start bit counts as the first received bit
					if (rsp_start) begin
						state <= rx_receive;
						bit_cnt <= 6'd1;
					end
				end
				rx_receive: begin
					bit_cnt <= bit_cnt + 6'd1;
					if (bit_cnt == last_bit)
						state <= rx_hold;
				end
				rx_hold: begin
					if (ack_out)
						state <= rx_idle;
				end
				default: state <= rx_idle;
			endcase
		end
	end

	always_ff @(posedge CLK_host) begin
		if (tx_done)
			shift_q <= '0;
		else if (rsp_start || state == rx_receive)
			shift_q <= {shift_q[`SD_CMD_FRAME_BITS-2:0], cmd_in};
	end

endmodule

`default_nettype wire

// ==== cmd_physical/cmd_tx_shifter.sv ====
// ============================================================
// CMD line transmitter with CRC7
// ============================================================

`default_nettype none

`include "sd_cmd_settings.svh"

module cmd_tx_shifter
	import sd_cmd_pkg::*;
(
	input wire logic CLK_host,
	input wire logic reset,
	input wire logic physical_inactive,
	input wire logic new_cmd_to_physical,
	input wire cmd_req_t cmd_to_physical,
	output logic ack_in,
	output logic tx_done,
	output logic cmd_out,
	output logic cmd_oe
);

	localparam int payload_bits = `SD_CMD_FRAME_BITS - 8;
	localparam logic [5:0] crc_first = 6'(`SD_CMD_FRAME_BITS - 8);
	localparam logic [5:0] last_bit = 6'(`SD_CMD_FRAME_BITS - 1);

	logic active;
	logic load;
	logic payload_phase;
	logic crc_fb;
	logic [5:0] bit_cnt;
	logic [payload_bits-1:0] payload_q;
	crc7_t crc_q;

	assign load = new_cmd_to_physical && !active;
	assign ack_in = load;
	assign payload_phase = (bit_cnt < crc_first);
	assign tx_done = active && (bit_cnt == last_bit);
	assign cmd_oe = active;
	assign crc_fb = crc_q[6] ^ payload_q[payload_bits-1];

	// Payload, then CRC7, then the end bit
	always_comb begin
		if (!active)
			cmd_out = 1'b1;
		else if (payload_phase)
			cmd_out = payload_q[payload_bits-1];
		else if (bit_cnt != last_bit)
			cmd_out = crc_q[6];
		else
			cmd_out = 1'b1;
	end

	always_ff @(posedge CLK_host) begin
		if (reset || physical_inactive) begin
			active <= 1'b0;
			bit_cnt <= '0;
		end else if (load) begin
			active <= 1'b1;
			bit_cnt <= '0;
		end else if (tx_done) begin
			active <= 1'b0;
			bit_cnt <= '0;
		end else if (active) begin
			bit_cnt <= bit_cnt + 6'd1;
		end
	end

	always_ff @(posedge CLK_host) begin
		if (load) begin
			payload_q <= {1'b0, 1'b1, cmd_to_physical.index, cmd_to_physical.arg};
			crc_q <= '0;
		end else if (active && payload_phase) begin
			payload_q <= {payload_q[payload_bits-2:0], 1'b0};
			// x^7 + x^3 + 1
			crc_q <= {crc_q[5:3], crc_q[2] ^ crc_fb, crc_q[1:0], crc_fb};
		end else if (active) begin
			crc_q <= {crc_q[5:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

// ==== common/sd_cmd_pkg.sv ====
// ============================================================
// SD command token types
// ============================================================

`default_nettype none

`include "sd_cmd_settings.svh"

package sd_cmd_pkg;

	// Command fields
	typedef logic [5:0] cmd_index_t;
	typedef logic [31:0] cmd_arg_t;

	// CRC7 over start, transmission, index and argument
	typedef logic [6:0] crc7_t;

	// Whole token as it travels on the CMD line
	typedef logic [`SD_CMD_FRAME_BITS-1:0] cmd_token_t;

	// Command passed from master to physical layer
	typedef struct packed {
		cmd_index_t index;
		cmd_arg_t arg;
	} cmd_req_t;

endpackage

`default_nettype wire

// ==== common/sd_cmd_settings.svh ====
// ============================================================
// SD command path settings
// ============================================================

`ifndef SD_CMD_SETTINGS_SVH
`define SD_CMD_SETTINGS_SVH

// Command and response token length
`define SD_CMD_FRAME_BITS 48

// Cycles after the last command bit allowed for the start bit
`define SD_CMD_NCR_MAX 64
`define SD_CMD_TIMER_BITS 7

// Card status field inside a short response
`define SD_RSP_STATUS_MSB 39
`define SD_RSP_STATUS_LSB 8

`endif

// ==== common/sd_host_reg_pkg.sv ====
// ============================================================
// Host register status types
// ============================================================

`default_nettype none

`include "sd_cmd_settings.svh"

package sd_host_reg_pkg;

	typedef logic [`SD_RSP_STATUS_MSB-`SD_RSP_STATUS_LSB:0] resp_status_t;

	typedef struct packed {
		logic cmd_busy;
		logic cmd_complete;
		logic timeout_error;
		resp_status_t response_status;
	} host_status_t;

	// One write strobe per field, per bit for the card status
	typedef struct packed {
		logic cmd_busy_en;
		logic cmd_complete_en;
		logic timeout_error_en;
		logic [$bits(resp_status_t)-1:0] response_status_en;
	} host_status_en_t;

endpackage

`default_nettype wire

// ==== design/sd_cmd_top.sv ====
// ============================================================
// SD host command path top
// ============================================================

`default_nettype none

module sd_cmd_top
	import sd_cmd_pkg::*, sd_host_reg_pkg::*;
(
	input wire logic CLK_host,
	input wire logic reset,
	input wire logic new_cmd,
	input wire cmd_req_t cmd_req,
	input wire logic physical_inactive,
	output host_status_t cmd_status,
	output host_status_en_t cmd_status_en,
	output logic cmd_out,
	output logic cmd_oe,
	input wire logic cmd_in
);

	logic new_cmd_to_physical;
	cmd_req_t cmd_to_physical;
	logic ack_in;
	logic ack_out;
	logic req_in;
	cmd_token_t cmd_response;
	logic tx_done;
	logic rsp_start;
	logic timeout_error_from_physical;

	cmd_master master_i (
		.CLK_host(CLK_host),
		.reset(reset),
		.physical_inactive(physical_inactive),
		.new_cmd(new_cmd),
		.cmd_req(cmd_req),
		.ack_in(ack_in),
		.req_in(req_in),
		.cmd_response(cmd_response),
		.timeout_error_from_physical(timeout_error_from_physical),
		.new_cmd_to_physical(new_cmd_to_physical),
		.cmd_to_physical(cmd_to_physical),
		.ack_out(ack_out),
		.cmd_status(cmd_status),
		.cmd_status_en(cmd_status_en)
	);

	cmd_tx_shifter tx_shifter_i (
		.CLK_host(CLK_host),
		.reset(reset),
		.physical_inactive(physical_inactive),
		.new_cmd_to_physical(new_cmd_to_physical),
		.cmd_to_physical(cmd_to_physical),
		.ack_in(ack_in),
		.tx_done(tx_done),
		.cmd_out(cmd_out),
		.cmd_oe(cmd_oe)
	);

	cmd_response_timer response_timer_i (
		.CLK_host(CLK_host),
		.reset(reset),
		.physical_inactive(physical_inactive),
		.tx_done(tx_done),
		.rsp_start(rsp_start),
		.timeout_error_from_physical(timeout_error_from_physical)
	);

	cmd_rx_capture rx_capture_i (
		.CLK_host(CLK_host),
		.reset(reset),
		.physical_inactive(physical_inactive),
		.tx_done(tx_done),
		.ack_out(ack_out),
		.cmd_in(cmd_in),
		.rsp_start(rsp_start),
		.req_in(req_in),
		.cmd_response(cmd_response)
	);

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+common
common/sd_cmd_pkg.sv
common/sd_host_reg_pkg.sv
cmd_master/cmd_master.sv
cmd_physical/cmd_tx_shifter.sv
cmd_physical/cmd_rx_capture.sv
cmd_physical/cmd_response_timer.sv
design/sd_cmd_top.sv
test/tb_clock_gen.sv
test/sd_cmd_sva.sv
test/sd_cmd_tb.sv

// ==== test/sd_cmd_sva.sv ====
// ============================================================
// Command master handshake assertions
// ============================================================

`default_nettype none

module sd_cmd_sva
	import sd_host_reg_pkg::*;
(
	input wire logic CLK_host,
	input wire logic reset,
	input wire logic req_in,
	input wire logic ack_out,
	input wire logic cmd_oe,
	input wire host_status_en_t cmd_status_en
);

	// Strobes rise and fall together
	strobes_together: assert property (@(posedge CLK_host) disable iff (reset)
		(&cmd_status_en) || !(|cmd_status_en))
		else $error("status strobes differ from each other");

	ack_needs_req: assert property (@(posedge CLK_host) disable iff (reset)
		ack_out |-> req_in)
		else $error("ack_out raised without req_in");

	no_drive_during_rsp: assert property (@(posedge CLK_host) disable iff (reset)
		req_in |-> !cmd_oe)
		else $error("cmd_oe high while a response is pending");

endmodule

`default_nettype wire

// ==== test/sd_cmd_tb.sv ====
// ============================================================
// SD command path testbench
// ============================================================

`default_nettype none

`include "sd_cmd_settings.svh"

module sd_cmd_tb
	import sd_cmd_pkg::*, sd_host_reg_pkg::*;
();

	localparam int num_tests = 7;
	localparam int clk_period = 4;
	localparam int reset_cycles = 16;
	localparam int watchdog_time = clk_period * (reset_cycles + num_tests *
		(2 * `SD_CMD_FRAME_BITS + `SD_CMD_NCR_MAX + 20));

	// delay -1 means the card stays silent, abort_at -1 means no abort
	typedef struct {
		string name;
		cmd_index_t index;
		cmd_arg_t arg;
		int delay;
		int abort_at;
		logic exp_timeout;
	} test_entry_t;

	logic CLK_host;
	logic reset;
	logic new_cmd;
	cmd_req_t cmd_req;
	logic physical_inactive;
	logic cmd_in;
	host_status_t cmd_status;
	host_status_en_t cmd_status_en;
	logic cmd_out;
	logic cmd_oe;

	test_entry_t tests[$];
	string current_test;
	logic [31:0] lfsr_q;

	tb_clock_gen #(.period(clk_period)) clock_gen_i (.clk(CLK_host));

	sd_cmd_top dut_i (
		.CLK_host(CLK_host),
		.reset(reset),
		.new_cmd(new_cmd),
		.cmd_req(cmd_req),
		.physical_inactive(physical_inactive),
		.cmd_status(cmd_status),
		.cmd_status_en(cmd_status_en),
		.cmd_out(cmd_out),
		.cmd_oe(cmd_oe),
		.cmd_in(cmd_in)
	);

	// Handshake checks on the master's ports, seen from the top
	bind sd_cmd_top sd_cmd_sva sva_i (
		.CLK_host(CLK_host),
		.reset(reset),
		.req_in(req_in),
		.ack_out(ack_out),
		.cmd_oe(cmd_oe),
		.cmd_status_en(cmd_status_en)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] draw_bits(input int n);
		logic [31:0] val;
		val = '0;
		repeat (n) begin
			lfsr_q = lfsr_step(lfsr_q);
			val = {val[30:0], lfsr_q[0]};
		end
		return val;
	endfunction

	// x^7 + x^3 + 1, MSB first
	function automatic crc7_t crc7_of(input logic [39:0] bits);
		crc7_t crc;
		logic fb;
		crc = '0;
		for (int i = 39; i >= 0; i--) begin
			fb = crc[6] ^ bits[i];
			crc = {crc[5:0], 1'b0};
			if (fb)
				crc = crc ^ 7'h09;
		end
		return crc;
	endfunction

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("Mismatch in %s (%s): expected %0h, actual %0h",
				current_test, what, expected, actual));
		end
	endtask

	task automatic check_idle();
		check("idle cmd_oe", 64'd0, 64'(cmd_oe));
		check("idle cmd_out", 64'd1, 64'(cmd_out));
		check("idle strobes", 64'd0, 64'(cmd_status_en));
		check("idle cmd_busy", 64'd0, 64'(cmd_status.cmd_busy));
	endtask

	task automatic run_entry(input test_entry_t e);
		cmd_token_t exp_token;
		cmd_token_t rsp_token;
		cmd_token_t tx_bits;
		cmd_arg_t rsp_payload;
		logic [31:0] exp_rsp_status;
		int oe_cycles;
		current_test = e.name;
		exp_token = {2'b01, e.index, e.arg, crc7_of({2'b01, e.index, e.arg}), 1'b1};
		rsp_payload = draw_bits(32);
		rsp_token = {2'b00, e.index, rsp_payload, 7'(draw_bits(7)), 1'b1};
		exp_rsp_status = e.exp_timeout ? 32'd0 : rsp_payload;
		@(posedge CLK_host);
		new_cmd <= 1'b1;
		cmd_req <= '{index: e.index, arg: e.arg};
		@(posedge CLK_host);
		new_cmd <= 1'b0;
		if (e.abort_at >= 0) begin
			@(negedge CLK_host);
			while (!cmd_oe)
				@(negedge CLK_host);
			repeat (e.abort_at) @(negedge CLK_host);
			@(posedge CLK_host);
			physical_inactive <= 1'b1;
			@(posedge CLK_host);
			physical_inactive <= 1'b0;
			repeat (8) begin
				@(negedge CLK_host);
				check_idle();
			end
		end else begin
			fork
				begin
					// Card model
					tx_bits = '0;
					oe_cycles = 0;
					@(negedge CLK_host);
					while (!cmd_oe)
						@(negedge CLK_host);
					while (cmd_oe) begin
						tx_bits = {tx_bits[`SD_CMD_FRAME_BITS-2:0], cmd_out};
						oe_cycles++;
						@(negedge CLK_host);
					end
					check("cmd_oe cycles", 64'(`SD_CMD_FRAME_BITS), 64'(oe_cycles));
					check("command token", 64'(exp_token), 64'(tx_bits));
					if (e.delay >= 0) begin
						repeat (e.delay) @(posedge CLK_host);
						for (int b = `SD_CMD_FRAME_BITS - 1; b >= 0; b--) begin
							@(posedge CLK_host);
							cmd_in <= rsp_token[b];
						end
						@(posedge CLK_host);
						cmd_in <= 1'b1;
					end
				end
				begin
					@(negedge CLK_host);
					while (!cmd_status_en.cmd_complete_en) begin
						check("busy before strobe", 64'd1, 64'(cmd_status.cmd_busy));
						check("early strobes", 64'd0, 64'(cmd_status_en));
						@(negedge CLK_host);
					end
					check("all strobes", 64'd1, 64'(&cmd_status_en));
					check("cmd_busy", 64'd0, 64'(cmd_status.cmd_busy));
					check("cmd_complete", 64'(!e.exp_timeout), 64'(cmd_status.cmd_complete));
					check("timeout_error", 64'(e.exp_timeout), 64'(cmd_status.timeout_error));
					check("response_status", 64'(exp_rsp_status),
						64'(cmd_status.response_status));
				end
			join
		end
		repeat (3) begin
			@(negedge CLK_host);
			check_idle();
		end
	endtask

	initial begin
		#(watchdog_time);
		stop_with_failure("Watchdog expired before the command table finished");
	end

	initial begin
		reset = 1'b1;
		new_cmd = 1'b0;
		cmd_req = '0;
		physical_inactive = 1'b0;
		cmd_in = 1'b1;
		lfsr_q = 32'hb875;
		current_test = "crc7 reference";
		// Known tokens CMD0 and CMD8
		check("crc7 cmd0", 64'h4a, 64'(crc7_of(40'h40_0000_0000)));
		check("crc7 cmd8", 64'h43, 64'(crc7_of(40'h48_0000_01aa)));
		tests.push_back('{"cmd8_if_cond", 6'd8, 32'h0000_01aa, 0, -1, 1'b0});
		tests.push_back('{"cmd17_read", 6'd17, draw_bits(32), 12, -1, 1'b0});
		tests.push_back('{"cmd55_late_rsp", 6'd55, draw_bits(32), 63, -1, 1'b0});
		tests.push_back('{"cmd0_no_rsp", 6'd0, 32'h0, -1, -1, 1'b1});
		tests.push_back('{"cmd24_abort", 6'd24, draw_bits(32), -1, 20, 1'b0});
		tests.push_back('{"cmd13_after_abort", 6'd13, draw_bits(32), 5, -1, 1'b0});
		tests.push_back('{"cmd9_no_rsp", 6'd9, draw_bits(32), -1, -1, 1'b1});
		repeat (reset_cycles) @(posedge CLK_host);
		reset <= 1'b0;
		@(negedge CLK_host);
		current_test = "after reset";
		check_idle();
		foreach (tests[i]) begin
			run_entry(tests[i]);
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
// ============================================================
// Testbench clock
// ============================================================

`default_nettype none

module tb_clock_gen #(
	parameter int period = 4
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(period / 2) clk = ~clk;

endmodule

`default_nettype wire
